/* project.f */
hw/img_path_pkg.sv
hw/axil_strobe_chan.sv
hw/img_path_ctrl_regs.sv
hw/img_path_readback.sv
hw/img_path_regs.sv
bench/tb_clk_gen.sv
bench/img_path_regs_chk.sv
bench/img_path_regs_tb.sv

/* Bender.yml */
package:
  name: img_path_regs

sources:
  - files:
      - hw/img_path_pkg.sv
      - hw/axil_strobe_chan.sv
      - hw/img_path_ctrl_regs.sv
      - hw/img_path_readback.sv
      - hw/img_path_regs.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/img_path_regs_chk.sv
      - bench/img_path_regs_tb.sv

/* bench/img_path_regs_tb.sv */
//------------------------------
// Image path register block testbench
// Directed AXI-lite tests with self checks
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module img_path_regs_tb
    import img_path_pkg::*;
;

    localparam int NUM_CH      = 2;
    localparam int CLK_NS      = 10;
    localparam int RST_CYCLES  = 10;
    localparam int HS_LIMIT    = 8;
    // Worst case transfer is about 10 cycles, doubled for margin
    localparam int NUM_XFERS   = 40;
    localparam int XFER_CYCLES = 12;
    localparam int WATCHDOG_NS = 2 * (RST_CYCLES + NUM_XFERS * XFER_CYCLES) * CLK_NS;

    logic s_axi_aclk;
    logic reg_rst;

    // AXI-lite master side
    reg_data_t awaddr, wdata, araddr, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    // Image path side
    logic im_rst, im_oe, dma_en, pool_flush, mmcm_locked, align_err;
    logic [POOL_WORDS-1:0] pool_push;
    pool_addr_t pool_din;
    logic [NUM_CH-1:0] int_clr;
    int_cnt_t [NUM_CH-1:0] int_cnt;

    integer seed;
    int errors;
    int checks;
    // Strobe counters
    int push_cnt [POOL_WORDS] = '{default: 0};
    int clr_cnt [NUM_CH] = '{default: 0};

    tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(RST_CYCLES)) u_clk (
        .clk_o (s_axi_aclk),
        .rst_o (reg_rst)
    );

    img_path_regs #(.NUM_CH(NUM_CH)) DUT (
        .s_axi_aclk        (s_axi_aclk),
        .reg_rst           (reg_rst),
        .s_axi_awaddr_i    (awaddr),
        .s_axi_awvalid_i   (awvalid),
        .s_axi_awready_o   (awready),
        .s_axi_wdata_i     (wdata),
        .s_axi_wstrb_i     (wstrb),
        .s_axi_wvalid_i    (wvalid),
        .s_axi_wready_o    (wready),
        .s_axi_bresp_o     (bresp),
        .s_axi_bvalid_o    (bvalid),
        .s_axi_bready_i    (bready),
        .s_axi_araddr_i    (araddr),
        .s_axi_arvalid_i   (arvalid),
        .s_axi_arready_o   (arready),
        .s_axi_rdata_o     (rdata),
        .s_axi_rresp_o     (rresp),
        .s_axi_rvalid_o    (rvalid),
        .s_axi_rready_i    (rready),
        .im_rst_o          (im_rst),
        .im_oe_o           (im_oe),
        .dma_en_o          (dma_en),
        .addr_pool_flush_o (pool_flush),
        .addr_pool_push_o  (pool_push),
        .addr_pool_din_o   (pool_din),
        .dma_int_clr_o     (int_clr),
        .mmcm_locked_i     (mmcm_locked),
        .align_err_i       (align_err),
        .dma_int_cnt_i     (int_cnt)
    );

    // Count every strobe cycle, sampled mid cycle
    always @(negedge s_axi_aclk) begin
        for (int w = 0; w < POOL_WORDS; w++) begin
            if (pool_push[w]) begin
                push_cnt[w]++;
            end
        end
        for (int c = 0; c < NUM_CH; c++) begin
            if (int_clr[c]) begin
                clr_cnt[c]++;
            end
        end
    end

    //------------------------------
    // Compare tasks
    //------------------------------
    task automatic check_word(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pool(input string name, input pool_addr_t exp, input pool_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Byte address of a register word
    function automatic reg_data_t index_to_addr(input reg_idx_t idx);
        return reg_data_t'(idx) << REG_IDX_LSB;
    endfunction

    //------------------------------
    // Bus transfers
    //------------------------------
    task automatic axil_write(input string name, input reg_data_t addr, input reg_data_t data);
        int cnt;
        int hold;
        hold = ($random(seed) & 3) + 1;
        @(negedge s_axi_aclk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cnt     = 0;
        // Ready expected two edges after the first sample
        do begin
            @(negedge s_axi_aclk);
            cnt++;
        end while (!awready && cnt < HS_LIMIT);
        if (!awready) begin
            errors++;
            $display("Error: %s: awready did not arrive within %0d cycles", name, HS_LIMIT);
        end
        check_word({name, " awready delay"}, 2, cnt);
        check_bit({name, " wready"}, 1'b1, wready);
        @(negedge s_axi_aclk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_bit({name, " awready width"}, 1'b0, awready);
        check_bit({name, " wready width"}, 1'b0, wready);
        check_bit({name, " bvalid rise"}, 1'b1, bvalid);
        check_word({name, " bresp"}, RESP_OKAY, bresp);
        // Back pressure
        repeat (hold) begin
            @(negedge s_axi_aclk);
            check_bit({name, " bvalid held"}, 1'b1, bvalid);
        end
        bready = 1'b1;
        @(negedge s_axi_aclk);
        bready = 1'b0;
        check_bit({name, " bvalid drop"}, 1'b0, bvalid);
    endtask

    task automatic axil_read(input string name, input reg_data_t addr, output reg_data_t data);
        int cnt;
        int hold;
        hold = ($random(seed) & 3) + 1;
        @(negedge s_axi_aclk);
        araddr  = addr;
        arvalid = 1'b1;
        cnt     = 0;
        do begin
            @(negedge s_axi_aclk);
            cnt++;
        end while (!arready && cnt < HS_LIMIT);
        if (!arready) begin
            errors++;
            $display("Error: %s: arready did not arrive within %0d cycles", name, HS_LIMIT);
        end
        check_word({name, " arready delay"}, 2, cnt);
        @(negedge s_axi_aclk);
        arvalid = 1'b0;
        check_bit({name, " arready width"}, 1'b0, arready);
        check_bit({name, " rvalid rise"}, 1'b1, rvalid);
        check_word({name, " rresp"}, RESP_OKAY, rresp);
        data = rdata;
        repeat (hold) begin
            @(negedge s_axi_aclk);
            check_bit({name, " rvalid held"}, 1'b1, rvalid);
        end
        rready = 1'b1;
        @(negedge s_axi_aclk);
        rready = 1'b0;
        check_bit({name, " rvalid drop"}, 1'b0, rvalid);
    endtask

    //------------------------------
    // Directed tests
    //------------------------------
    task automatic reset_values();
        @(negedge s_axi_aclk);
        check_bit("reset awready", 1'b0, awready);
        check_bit("reset wready", 1'b0, wready);
        check_bit("reset arready", 1'b0, arready);
        check_bit("reset bvalid", 1'b0, bvalid);
        check_bit("reset rvalid", 1'b0, rvalid);
        check_word("reset push", '0, reg_data_t'(pool_push));
        check_word("reset clear", '0, reg_data_t'(int_clr));
        check_bit("reset im_rst", 1'b1, im_rst);
        check_bit("reset im_oe", 1'b0, im_oe);
        check_bit("reset dma_en", 1'b0, dma_en);
        check_bit("reset flush", 1'b0, pool_flush);
        check_word("reset rdata", '0, rdata);
    endtask

    task automatic handshake_timing();
        reg_data_t d;
        reg_data_t rd;
        // Read only register, bit 0 low would show up as a stray path reset write
        d    = $random(seed);
        d[0] = 1'b0;
        axil_write("timing write", index_to_addr(IDX_LINK_STAT), d);
        check_bit("timing im_rst", 1'b1, im_rst);
        // Status inputs still low here
        axil_read("timing read", index_to_addr(IDX_LINK_STAT), rd);
        check_word("timing link status", '0, rd);
    endtask

    task automatic control_levels();
        reg_data_t d;
        repeat (4) begin
            d = $random(seed);
            axil_write("path reset write", index_to_addr(IDX_PATH_RST), d);
            check_bit("path reset", d[0], im_rst);
            check_bit("output enable", d[4], im_oe);
            d = $random(seed);
            axil_write("dma ctrl write", index_to_addr(IDX_DMA_CTRL), d);
            check_bit("dma enable", d[0], dma_en);
            d = $random(seed);
            axil_write("pool ctrl write", index_to_addr(IDX_POOL_CTRL), d);
            check_bit("pool flush", d[0], pool_flush);
        end
    endtask

    task automatic address_pool();
        reg_data_t lo;
        reg_data_t hi;
        int base [POOL_WORDS];
        lo   = $random(seed);
        hi   = $random(seed);
        base = push_cnt;
        axil_write("pool lo write", index_to_addr(IDX_POOL_LO), lo);
        check_word("pool lo push", base[0] + 1, push_cnt[0]);
        check_word("pool lo no hi push", base[1], push_cnt[1]);
        axil_write("pool hi write", index_to_addr(IDX_POOL_HI), hi);
        check_word("pool hi no lo push", base[0] + 1, push_cnt[0]);
        check_word("pool hi push", base[1] + 1, push_cnt[1]);
        check_pool("pool address", {hi, lo}, pool_din);
    endtask

    task automatic interrupt_regs();
        reg_data_t d;
        reg_data_t rd;
        int base [NUM_CH];
        for (int n = 0; n < NUM_CH; n++) begin
            // Bit 0 set clears, bit 0 clear does nothing
            for (int set = 1; set >= 0; set--) begin
                base = clr_cnt;
                d    = $random(seed);
                d[0] = set[0];
                axil_write("int clear write", index_to_addr(reg_idx_t'(IDX_INT_BASE + n)), d);
                for (int c = 0; c < NUM_CH; c++) begin
                    check_word("int clear count", base[c] + ((c == n && set == 1) ? 1 : 0),
                               clr_cnt[c]);
                end
            end
        end
        mmcm_locked = $random(seed);
        align_err   = $random(seed);
        for (int n = 0; n < NUM_CH; n++) begin
            int_cnt[n] = $random(seed);
        end
        axil_read("link status read", index_to_addr(IDX_LINK_STAT), rd);
        check_word("link status", {30'd0, align_err, mmcm_locked}, rd);
        for (int n = 0; n < NUM_CH; n++) begin
            axil_read("int count read", index_to_addr(reg_idx_t'(IDX_INT_BASE + n)), rd);
            check_word("int count", {27'd0, int_cnt[n]}, rd);
        end
    endtask

    task automatic unmapped_reads();
        reg_data_t a;
        reg_data_t rd;
        reg_idx_t  idx;
        repeat (6) begin
            a   = $random(seed);
            idx = a[REG_IDX_MSB:REG_IDX_LSB];
            // Steer away from the mapped read indices
            if (idx == IDX_LINK_STAT || (idx >= IDX_INT_BASE && idx < IDX_INT_BASE + NUM_CH)) begin
                a[REG_IDX_MSB:REG_IDX_LSB] = 8'h01;
            end
            axil_read("unmapped read", a, rd);
            check_word("unmapped data", RD_UNMAPPED, rd);
        end
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed        = 32'h179ba43a;
        errors      = 0;
        checks      = 0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = 4'hf;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        mmcm_locked = 1'b0;
        align_err   = 1'b0;
        int_cnt     = '0;
        @(negedge reg_rst);
        reset_values();
        handshake_timing();
        control_levels();
        address_pool();
        interrupt_regs();
        unmapped_reads();
        // Bound handshake assertions count as errors too
        errors = errors + DUT.u_chk.assert_fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_chk.assert_fails);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/img_path_regs_chk.sv */
//------------------------------
// Handshake assertions
// Bound into the register block
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module img_path_regs_chk
    import img_path_pkg::*;
(
    input  wire                    s_axi_aclk,
    input  wire                    reg_rst,
    input  logic                   awready_i,
    input  logic                   arready_i,
    input  logic                   bvalid_i,
    input  logic                   bready_i,
    input  logic [POOL_WORDS-1:0]  push_i
);

    // Assertion failures seen so far
    int assert_fails = 0;

    // Ready strobes last one cycle
    awready_one_cycle: assert property (@(posedge s_axi_aclk) disable iff (reg_rst)
        $rose(awready_i) |=> !awready_i)
        else begin
            $error("awready held longer than one cycle");
            assert_fails++;
        end

    arready_one_cycle: assert property (@(posedge s_axi_aclk) disable iff (reg_rst)
        $rose(arready_i) |=> !arready_i)
        else begin
            $error("arready held longer than one cycle");
            assert_fails++;
        end

    // One push strobe per pool word
    for (genvar w = 0; w < POOL_WORDS; w++) begin : g_push
        push_one_cycle: assert property (@(posedge s_axi_aclk) disable iff (reg_rst)
            $rose(push_i[w]) |=> !push_i[w])
            else begin
                $error("pool push %0d held longer than one cycle", w);
                assert_fails++;
            end
    end

    // Response only drops once taken
    bvalid_waits: assert property (@(posedge s_axi_aclk) disable iff (reg_rst)
        $fell(bvalid_i) |-> $past(bready_i))
        else begin
            $error("bvalid fell without bready");
            assert_fails++;
        end

endmodule

bind img_path_regs img_path_regs_chk u_chk (
    .s_axi_aclk (s_axi_aclk),
    .reg_rst    (reg_rst),
    .awready_i  (s_axi_awready_o),
    .arready_i  (s_axi_arready_o),
    .bvalid_i   (s_axi_bvalid_o),
    .bready_i   (s_axi_bready_i),
    .push_i     (addr_pool_push_o)
);

`default_nettype wire

/* bench/tb_clk_gen.sv */
//------------------------------
// Testbench clock and reset
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    // Free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* hw/img_path_regs.sv */
//------------------------------
// Image path register block
// AXI-lite slave for sensor and DMA control
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module img_path_regs
    import img_path_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  wire                    s_axi_aclk,
    input  wire                    reg_rst,
    //------------------------------
    // AXI-lite slave
    //------------------------------
    input  reg_data_t              s_axi_awaddr_i,
    input  logic                   s_axi_awvalid_i,
    output logic                   s_axi_awready_o,
    input  reg_data_t              s_axi_wdata_i,
    // Byte strobes ignored, full word writes only
    input  logic [3:0]             s_axi_wstrb_i,
    input  logic                   s_axi_wvalid_i,
    output logic                   s_axi_wready_o,
    output logic [1:0]             s_axi_bresp_o,
    output logic                   s_axi_bvalid_o,
    input  logic                   s_axi_bready_i,
    input  reg_data_t              s_axi_araddr_i,
    input  logic                   s_axi_arvalid_i,
    output logic                   s_axi_arready_o,
    output reg_data_t              s_axi_rdata_o,
    output logic [1:0]             s_axi_rresp_o,
    output logic                   s_axi_rvalid_o,
    input  logic                   s_axi_rready_i,
    //------------------------------
    // Image path controls
    //------------------------------
    output logic                   im_rst_o,
    output logic                   im_oe_o,
    output logic                   dma_en_o,
    output logic                   addr_pool_flush_o,
    output logic [POOL_WORDS-1:0]  addr_pool_push_o,
    output pool_addr_t             addr_pool_din_o,
    output logic [NUM_CH-1:0]      dma_int_clr_o,
    // Image path status
    input  logic                   mmcm_locked_i,
    input  logic                   align_err_i,
    input  int_cnt_t [NUM_CH-1:0]  dma_int_cnt_i
);

    // Write needs address and data valid together
    logic we_lvl;
    logic we_pulse;
    logic re_pulse;

    assign we_lvl = s_axi_awvalid_i & s_axi_wvalid_i;

    // Both write readies share the one strobe
    assign s_axi_awready_o = we_pulse;
    assign s_axi_wready_o  = we_pulse;
    assign s_axi_arready_o = re_pulse;

    // No error responses
    assign s_axi_bresp_o = RESP_OKAY;
    assign s_axi_rresp_o = RESP_OKAY;

    //------------------------------
    // Write and read channels
    //------------------------------
    axil_strobe_chan u_wr_chan (
        .s_axi_aclk   (s_axi_aclk),
        .reg_rst      (reg_rst),
        .req_i        (we_lvl),
        .resp_ready_i (s_axi_bready_i),
        .req_pulse_o  (we_pulse),
        .resp_valid_o (s_axi_bvalid_o)
    );

    axil_strobe_chan u_rd_chan (
        .s_axi_aclk   (s_axi_aclk),
        .reg_rst      (reg_rst),
        .req_i        (s_axi_arvalid_i),
        .resp_ready_i (s_axi_rready_i),
        .req_pulse_o  (re_pulse),
        .resp_valid_o (s_axi_rvalid_o)
    );

    //------------------------------
    // Register file
    //------------------------------
    img_path_ctrl_regs #(
        .NUM_CH (NUM_CH)
    ) u_ctrl_regs (
        .s_axi_aclk        (s_axi_aclk),
        .reg_rst           (reg_rst),
        .we_lvl_i          (we_lvl),
        .we_pulse_i        (we_pulse),
        .awaddr_i          (s_axi_awaddr_i),
        .wdata_i           (s_axi_wdata_i),
        .im_rst_o          (im_rst_o),
        .im_oe_o           (im_oe_o),
        .dma_en_o          (dma_en_o),
        .addr_pool_flush_o (addr_pool_flush_o),
        .addr_pool_push_o  (addr_pool_push_o),
        .addr_pool_din_o   (addr_pool_din_o),
        .dma_int_clr_o     (dma_int_clr_o)
    );

    img_path_readback #(
        .NUM_CH (NUM_CH)
    ) u_readback (
        .s_axi_aclk    (s_axi_aclk),
        .reg_rst       (reg_rst),
        .re_pulse_i    (re_pulse),
        .araddr_i      (s_axi_araddr_i),
        .mmcm_locked_i (mmcm_locked_i),
        .align_err_i   (align_err_i),
        .dma_int_cnt_i (dma_int_cnt_i),
        .rdata_o       (s_axi_rdata_o)
    );

endmodule

`default_nettype wire

/* hw/img_path_readback.sv */
//------------------------------
// Image path status readback
// Read decode of link status and interrupt counts
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module img_path_readback
    import img_path_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  wire                    s_axi_aclk,
    input  wire                    reg_rst,
    // Read strobe from the read channel
    input  logic                   re_pulse_i,
    input  reg_data_t              araddr_i,
    // Sensor link status
    input  logic                   mmcm_locked_i,
    input  logic                   align_err_i,
    // Pending interrupt counts, entry n is channel n
    input  int_cnt_t [NUM_CH-1:0]  dma_int_cnt_i,
    output reg_data_t              rdata_o
);

    reg_idx_t  rd_idx;
    reg_data_t rd_sel;

    assign rd_idx = araddr_i[REG_IDX_MSB:REG_IDX_LSB];

    //------------------------------
    // Read mux
    //------------------------------
    always_comb begin
        // Anything not mapped reads as all ones
        rd_sel = RD_UNMAPPED;
        if (rd_idx == IDX_LINK_STAT) begin
            rd_sel    = '0;
            rd_sel[0] = mmcm_locked_i;
            rd_sel[1] = align_err_i;
        end
        // Interrupt counts, zero extended
        for (int n = 0; n < NUM_CH; n++) begin
            if (rd_idx == reg_idx_t'(IDX_INT_BASE + n)) begin
                rd_sel = reg_data_t'(dma_int_cnt_i[n]);
            end
        end
    end

    // Loaded at k+2 together with rvalid rising, then held
    always_ff @(posedge s_axi_aclk or posedge reg_rst) begin
        if (reg_rst) begin
            rdata_o <= '0;
        end else if (re_pulse_i) begin
            rdata_o <= rd_sel;
        end
    end

endmodule

`default_nettype wire

/* hw/img_path_ctrl_regs.sv */
//------------------------------
// Image path control registers
// Write decode into levels, pool words and pulses
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module img_path_ctrl_regs
    import img_path_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  wire                    s_axi_aclk,
    input  wire                    reg_rst,
    // Combined write request level and its edge strobe
    input  logic                   we_lvl_i,
    input  logic                   we_pulse_i,
    input  reg_data_t              awaddr_i,
    input  reg_data_t              wdata_i,
    // Sensor and DMA control levels
    output logic                   im_rst_o,
    output logic                   im_oe_o,
    output logic                   dma_en_o,
    output logic                   addr_pool_flush_o,
    // Address pool interface
    output logic [POOL_WORDS-1:0]  addr_pool_push_o,
    output pool_addr_t             addr_pool_din_o,
    // Interrupt clear strobes, one per channel
    output logic [NUM_CH-1:0]      dma_int_clr_o
);

    localparam int WORD_W = $bits(reg_data_t);

    // Word index of the current write
    reg_idx_t                wr_idx;
    // Pool word select, bit 0 low word
    logic [POOL_WORDS-1:0]   pool_hit;
    // Interrupt register select per channel
    logic [NUM_CH-1:0]       int_hit;

    assign wr_idx = awaddr_i[REG_IDX_MSB:REG_IDX_LSB];

    //------------------------------
    // Address decode
    //------------------------------
    assign pool_hit = {wr_idx == IDX_POOL_HI, wr_idx == IDX_POOL_LO};

    always_comb begin
        for (int n = 0; n < NUM_CH; n++) begin
            int_hit[n] = (wr_idx == reg_idx_t'(IDX_INT_BASE + n));
        end
    end

    //------------------------------
    // Level registers
    //------------------------------
    // Written from the request level, so they follow edge k
    always_ff @(posedge s_axi_aclk or posedge reg_rst) begin
        if (reg_rst) begin
            // Image path held in reset until software releases it
            im_rst_o          <= 1'b1;
            im_oe_o           <= 1'b0;
            dma_en_o          <= 1'b0;
            addr_pool_flush_o <= 1'b0;
        end else if (we_lvl_i) begin
            if (wr_idx == IDX_PATH_RST) begin
                im_rst_o <= wdata_i[0];
                im_oe_o  <= wdata_i[4];
            end
            if (wr_idx == IDX_DMA_CTRL) begin
                dma_en_o <= wdata_i[0];
            end
            if (wr_idx == IDX_POOL_CTRL) begin
                addr_pool_flush_o <= wdata_i[0];
            end
        end
    end

    //------------------------------
    // Pool words
    //------------------------------
    // Selected half captured while the request is up
    always_ff @(posedge s_axi_aclk) begin
        for (int w = 0; w < POOL_WORDS; w++) begin
            if (we_lvl_i && pool_hit[w]) begin
                addr_pool_din_o[w*WORD_W +: WORD_W] <= wdata_i;
            end
        end
    end

    //------------------------------
    // Push and clear strobes
    //------------------------------
    // Registered from the write strobe, high in the cycle bvalid rises
    always_ff @(posedge s_axi_aclk or posedge reg_rst) begin
        if (reg_rst) begin
            addr_pool_push_o <= '0;
            dma_int_clr_o    <= '0;
        end else begin
            // One push per written pool word
            addr_pool_push_o <= pool_hit & {POOL_WORDS{we_pulse_i}};
            // Clear only when bit 0 of the data is set
            dma_int_clr_o    <= int_hit & {NUM_CH{we_pulse_i & wdata_i[0]}};
        end
    end

endmodule

`default_nettype wire

/* hw/axil_strobe_chan.sv */
//------------------------------
// AXI-lite strobe channel
// Request edge to ready pulse, held response valid
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module axil_strobe_chan (
    input  wire  s_axi_aclk,
    input  wire  reg_rst,
    // Request level from the master
    input  logic req_i,
    // Master ready for the response
    input  logic resp_ready_i,
    // One-cycle strobe, doubles as the AXI ready
    output logic req_pulse_o,
    // Response valid, held until accepted
    output logic resp_valid_o
);

    // Two delayed copies of the request level
    logic req_d;
    logic req_dd;

    //------------------------------
    // Request edge detect
    //------------------------------
    // First edge sampling the request is k
    // Pulse rises at k+1 and falls at k+2
    always_ff @(posedge s_axi_aclk or posedge reg_rst) begin
        if (reg_rst) begin
            req_d       <= 1'b0;
            req_dd      <= 1'b0;
            req_pulse_o <= 1'b0;
        end else begin
            req_d       <= req_i;
            req_dd      <= req_d;
            // Rising edge only, one strobe per request
            req_pulse_o <= req_d & ~req_dd;
        end
    end

    //------------------------------
    // Response valid
    //------------------------------
    // Set at k+2 from the strobe
    // Cleared only once the master takes it
    always_ff @(posedge s_axi_aclk or posedge reg_rst) begin
        if (reg_rst) begin
            resp_valid_o <= 1'b0;
        end else if (req_pulse_o) begin
            resp_valid_o <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/img_path_pkg.sv */
//------------------------------
// Image path register map
// Word indices, bus types and fixed read values
//------------------------------
`default_nettype none

package img_path_pkg;

    //------------------------------
    // Bus and payload types
    //------------------------------
    // One AXI-lite data word
    typedef logic [31:0] reg_data_t;
    // Word index taken from the byte address
    typedef logic [7:0]  reg_idx_t;
    // Frame address for the DMA pool, built from two words
    typedef logic [63:0] pool_addr_t;
    // Pending interrupt count of one DMA channel
    typedef logic [4:0]  int_cnt_t;

    // Index field position inside the byte address
    localparam int REG_IDX_LSB = 2;
    localparam int REG_IDX_MSB = 9;

    //------------------------------
    // Register indices
    //------------------------------
    // Bit 0 path reset, bit 4 sensor output enable
    localparam reg_idx_t IDX_PATH_RST  = 8'h00;
    // Read only, bit 0 clock lock, bit 1 alignment error
    localparam reg_idx_t IDX_LINK_STAT = 8'h08;
    // Bit 0 DMA enable
    localparam reg_idx_t IDX_DMA_CTRL  = 8'he0;
    // Bit 0 pool flush
    localparam reg_idx_t IDX_POOL_CTRL = 8'hf0;
    // Low and high halves of one pool address
    localparam reg_idx_t IDX_POOL_LO   = 8'hf1;
    localparam reg_idx_t IDX_POOL_HI   = 8'hf2;
    // Channel n interrupt register sits at base plus n
    localparam reg_idx_t IDX_INT_BASE  = 8'hf8;

    // Words per pool address
    localparam int POOL_WORDS = 2;

    // Fixed response code and unmapped read value
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam reg_data_t  RD_UNMAPPED = 32'hffff_ffff;

endpackage

`default_nettype wire
